// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_mem_subsys
FILELIST  := project.f
OBJDIR    := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: hdl/axi_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_arbiter (
  input  logic              clk,
  input  logic              rst,
  input  axi_pkg::axi_req_t m0_req,
  output axi_pkg::axi_rsp_t m0_rsp,
  input  axi_pkg::axi_req_t m1_req,
  output axi_pkg::axi_rsp_t m1_rsp,
  output axi_pkg::axi_req_t s_req,
  input  axi_pkg::axi_rsp_t s_rsp
);

  logic busy;   // Grant locked until the response.
  logic grant;  // Master holding the bus.
  logic last;   // Master served most recently.
  logic want0;
  logic want1;
  logic pick;   // Choice made while idle.
  logic cur;    // Master routed this cycle.
  logic active;
  logic done;

  assign want0 = m0_req.ar.valid || m0_req.aw.valid;
  assign want1 = m1_req.ar.valid || m1_req.aw.valid;

  // Round robin on a tie, otherwise whoever asks.
  always_comb begin
    if (want0 && want1) begin
      pick = ~last;
    end else begin
      pick = want1;
    end
  end

  assign cur    = busy ? grant : pick;  // Same-cycle grant when idle.
  assign active = busy || want0 || want1;

  always_comb begin
    s_req  = '0;
    m0_rsp = '0;
    m1_rsp = '0;
    if (active) begin
      if (cur) begin
        s_req  = m1_req;
        m1_rsp = s_rsp;
      end else begin
        s_req  = m0_req;
        m0_rsp = s_rsp;
      end
    end
  end

  // Transaction ends on R or B.
  assign done = (s_rsp.r.valid && s_req.rready) || (s_rsp.b.valid && s_req.bready);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      grant <= 1'b0;
      last  <= 1'b1;  // Master 0 wins the first tie.
    end else if (!busy) begin
      if (want0 || want1) begin
        busy  <= 1'b1;
        grant <= pick;
        last  <= pick;
      end
    end else if (done) begin
      busy <= 1'b0;  // Release.
    end
  end

endmodule

`default_nettype wire

// File: hdl/axi_pkg.sv
`default_nettype none

package axi_pkg;

  localparam logic [1:0] resp_okay = 2'b00;  // Only response the slave gives.

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;  // Byte address.
  } axi_aw_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic [3:0]  strb;  // One bit per byte lane.
  } axi_w_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] resp;
  } axi_b_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;  // Byte address.
  } axi_ar_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic [1:0]  resp;
  } axi_r_t;

  // Master to slave.
  typedef struct packed {
    axi_aw_t aw;
    axi_w_t  w;
    axi_ar_t ar;
    logic    bready;
    logic    rready;
  } axi_req_t;

  // Slave to master.
  typedef struct packed {
    logic    awready;
    logic    wready;
    logic    arready;
    axi_b_t  b;
    axi_r_t  r;
  } axi_rsp_t;

endpackage

`default_nettype wire

// File: hdl/axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_sram #(
  parameter int mem_words = 1024
) (
  input  logic              clk,
  input  logic              rst,
  input  axi_pkg::axi_req_t bus_req,
  output axi_pkg::axi_rsp_t bus_rsp
);

  logic [31:0] mem [mem_words];
  logic [31:0] widx;     // Write word index.
  logic [31:0] ridx;     // Read word index.
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic        bvalid_q;
  logic        idle;
  logic        wr_fire;
  logic        rd_fire;

  assign widx = (bus_req.aw.addr >> 2) % mem_words;  // Wraps over the depth.
  assign ridx = (bus_req.ar.addr >> 2) % mem_words;

  assign idle = !rvalid_q && !bvalid_q;

  always_comb begin
    bus_rsp         = '0;
    bus_rsp.arready = idle;
    bus_rsp.awready = idle && bus_req.aw.valid && bus_req.w.valid && !bus_req.ar.valid;
    bus_rsp.wready  = bus_rsp.awready;  // AW and W taken together.
    bus_rsp.r.valid = rvalid_q;
    bus_rsp.r.data  = rdata_q;
    bus_rsp.r.resp  = axi_pkg::resp_okay;
    bus_rsp.b.valid = bvalid_q;
    bus_rsp.b.resp  = axi_pkg::resp_okay;
  end

  assign rd_fire = bus_req.ar.valid && bus_rsp.arready;
  assign wr_fire = bus_rsp.awready;

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (bus_req.rready) begin
        rvalid_q <= 1'b0;  // Held until taken.
      end
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (bus_req.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // Array and read data.
  always_ff @(posedge clk) begin
    if (rd_fire) rdata_q <= mem[ridx];
    if (wr_fire) begin
      for (int i = 0; i < 4; i++) begin
        if (bus_req.w.strb[i]) mem[widx][8*i +: 8] <= bus_req.w.data[8*i +: 8];  // Strobed byte.
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  output logic                req_ready,
  input  lsu_pkg::fetch_req_t req,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output lsu_pkg::word_t      inst,
  output axi_pkg::axi_req_t   bus_req,
  input  axi_pkg::axi_rsp_t   bus_rsp
);

  typedef enum logic [1:0] {
    st_idle,  // Waiting for a pc.
    st_addr,  // AR on the bus.
    st_resp,  // Waiting for R.
    st_done   // Word held until taken.
  } state_t;

  state_t         state;
  lsu_pkg::word_t pc_q;
  lsu_pkg::word_t inst_q;

  always_comb begin
    bus_req          = '0;  // Write channels stay quiet.
    bus_req.ar.valid = (state == st_addr);
    bus_req.ar.addr  = {pc_q[31:2], 2'b00};  // Word aligned.
    bus_req.rready   = (state == st_resp);
  end

  assign req_ready = (state == st_idle);
  assign rsp_valid = (state == st_done);
  assign inst      = inst_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (req_valid) state <= st_addr;
        st_addr: if (bus_rsp.arready) state <= st_resp;
        st_resp: if (bus_rsp.r.valid) state <= st_done;
        st_done: if (rsp_ready) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) pc_q <= req.pc;
    if (bus_rsp.r.valid && bus_req.rready) inst_q <= bus_rsp.r.data;  // Capture on R.
  end

endmodule

`default_nettype wire

// File: hdl/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  output logic              req_ready,
  input  lsu_pkg::mem_req_t req,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output lsu_pkg::mem_rsp_t rsp,
  output axi_pkg::axi_req_t bus_req,
  input  axi_pkg::axi_rsp_t bus_rsp
);

  typedef enum logic [2:0] {
    st_idle,   // Waiting for a request.
    st_addr,   // AR, or AW and W, on the bus.
    st_wwait,  // Store sent, waiting for B.
    st_resp,   // Load sent, waiting for R.
    st_done    // Result held for the requester.
  } state_t;

  state_t            state;
  lsu_pkg::mem_req_t req_q;    // Request under way.
  lsu_pkg::word_t    rdata_q;  // Raw word from R.
  logic              aw_done;  // AW handshake seen.
  logic              w_done;   // W handshake seen.
  logic              aw_fire;
  logic              w_fire;
  logic              ar_fire;
  logic              r_fire;
  logic              b_fire;
  logic [1:0]        off;
  lsu_pkg::word_t    st_data;
  logic [3:0]        st_strb;
  lsu_pkg::word_t    byte_lane;
  lsu_pkg::word_t    half_lane;
  lsu_pkg::word_t    ld_data;

  assign off = req_q.addr[1:0];  // Byte offset within the word.

  assign aw_fire = bus_req.aw.valid && bus_rsp.awready;
  assign w_fire  = bus_req.w.valid && bus_rsp.wready;
  assign ar_fire = bus_req.ar.valid && bus_rsp.arready;
  assign r_fire  = bus_rsp.r.valid && bus_req.rready;
  assign b_fire  = bus_rsp.b.valid && bus_req.bready;

  // Store data copied into every lane, strobe picks the right one.
  always_comb begin
    case (req_q.size)
      lsu_pkg::size_b, lsu_pkg::size_bu: begin
        st_data = {4{req_q.data[7:0]}};
        st_strb = 4'b0001 << off;
      end
      lsu_pkg::size_h, lsu_pkg::size_hu: begin
        st_data = {2{req_q.data[15:0]}};
        st_strb = 4'b0011 << {off[1], 1'b0};  // Half aligned.
      end
      default: begin
        st_data = req_q.data;
        st_strb = 4'b1111;
      end
    endcase
  end

  // Bring the addressed lane down to bit 0.
  assign byte_lane = rdata_q >> {off, 3'b000};
  assign half_lane = rdata_q >> {off[1], 4'b0000};

  always_comb begin
    case (req_q.size)
      lsu_pkg::size_b:  ld_data = {{24{byte_lane[7]}}, byte_lane[7:0]};
      lsu_pkg::size_h:  ld_data = {{16{half_lane[15]}}, half_lane[15:0]};
      lsu_pkg::size_bu: ld_data = {24'b0, byte_lane[7:0]};
      lsu_pkg::size_hu: ld_data = {16'b0, half_lane[15:0]};
      default:          ld_data = rdata_q;  // Word passes through.
    endcase
  end

  // Bus outputs decoded from the state.
  always_comb begin
    bus_req          = '0;
    bus_req.ar.valid = (state == st_addr) && !req_q.store;
    bus_req.ar.addr  = req_q.addr;
    bus_req.aw.valid = (state == st_addr) && req_q.store && !aw_done;
    bus_req.aw.addr  = req_q.addr;
    bus_req.w.valid  = (state == st_addr) && req_q.store && !w_done;
    bus_req.w.data   = st_data;
    bus_req.w.strb   = st_strb;
    bus_req.rready   = (state == st_resp);
    bus_req.bready   = (state == st_wwait);
  end

  assign req_ready = (state == st_idle);
  assign rsp_valid = (state == st_done);
  assign rsp.data  = req_q.store ? '0 : ld_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req_valid) begin
            state   <= st_addr;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        st_addr: begin
          if (req_q.store) begin
            if (aw_fire) aw_done <= 1'b1;
            if (w_fire) w_done <= 1'b1;
            if ((aw_done || aw_fire) && (w_done || w_fire)) state <= st_wwait;  // Both sent.
          end else if (ar_fire) begin
            state <= st_resp;
          end
        end
        st_wwait: if (b_fire) state <= st_done;
        st_resp:  if (r_fire) state <= st_done;
        st_done:  if (rsp_ready) state <= st_idle;  // Result taken.
        default:  state <= st_idle;
      endcase
    end
  end

  // Payload registers.
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) req_q <= req;
    if (r_fire) rdata_q <= bus_rsp.r.data;
  end

endmodule

`default_nettype wire

// File: hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  typedef logic [31:0] word_t;

  // Width codes as in funct3 of RV32 loads and stores.
  typedef enum logic [2:0] {
    size_b  = 3'b000,  // Signed byte.
    size_h  = 3'b001,  // Signed half.
    size_w  = 3'b010,  // Full word.
    size_bu = 3'b100,  // Unsigned byte.
    size_hu = 3'b101   // Unsigned half.
  } mem_size_t;

  typedef struct packed {
    logic      store;  // High for a store, low for a load.
    mem_size_t size;
    word_t     addr;   // Byte address.
    word_t     data;   // Store data, right aligned.
  } mem_req_t;

  typedef struct packed {
    word_t data;  // Extended load data, zero for stores.
  } mem_rsp_t;

  typedef struct packed {
    word_t pc;
  } fetch_req_t;

endpackage

`default_nettype wire

// File: hdl/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys #(
  parameter int mem_words = 1024
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,        // LSU request.
  output logic                req_ready,
  input  lsu_pkg::mem_req_t   req,
  output logic                rsp_valid,        // LSU response.
  input  logic                rsp_ready,
  output lsu_pkg::mem_rsp_t   rsp,
  input  logic                fetch_req_valid,  // Fetch request.
  output logic                fetch_req_ready,
  input  lsu_pkg::fetch_req_t fetch_req,
  output logic                fetch_rsp_valid,  // Fetch response.
  input  logic                fetch_rsp_ready,
  output lsu_pkg::word_t      fetch_inst
);

  axi_pkg::axi_req_t lsu_bus_req;
  axi_pkg::axi_rsp_t lsu_bus_rsp;
  axi_pkg::axi_req_t fetch_bus_req;
  axi_pkg::axi_rsp_t fetch_bus_rsp;
  axi_pkg::axi_req_t sram_req;
  axi_pkg::axi_rsp_t sram_rsp;

  lsu i_lsu (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .bus_req   (lsu_bus_req),
    .bus_rsp   (lsu_bus_rsp)
  );

  fetch_unit i_fetch (
    .clk       (clk),
    .rst       (rst),
    .req_valid (fetch_req_valid),
    .req_ready (fetch_req_ready),
    .req       (fetch_req),
    .rsp_valid (fetch_rsp_valid),
    .rsp_ready (fetch_rsp_ready),
    .inst      (fetch_inst),
    .bus_req   (fetch_bus_req),
    .bus_rsp   (fetch_bus_rsp)
  );

  // LSU is master 0, fetch is master 1.
  axi_arbiter i_arb (
    .clk    (clk),
    .rst    (rst),
    .m0_req (lsu_bus_req),
    .m0_rsp (lsu_bus_rsp),
    .m1_req (fetch_bus_req),
    .m1_rsp (fetch_bus_rsp),
    .s_req  (sram_req),
    .s_rsp  (sram_rsp)
  );

  axi_sram #(
    .mem_words (mem_words)
  ) i_sram (
    .clk     (clk),
    .rst     (rst),
    .bus_req (sram_req),
    .bus_rsp (sram_rsp)
  );

endmodule

`default_nettype wire

// File: project.f
hdl/axi_pkg.sv
hdl/lsu_pkg.sv
hdl/lsu.sv
hdl/fetch_unit.sv
hdl/axi_arbiter.sv
hdl/axi_sram.sv
hdl/mem_subsys.sv
sim/tb_mem_subsys.sv

// File: sim/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

  localparam int timeout_cycles = 200;  // Per handshake wait.
  localparam int test_words     = 64;   // Window exercised by the tests.

  logic                clk;
  logic                rst;
  logic                req_valid;
  logic                req_ready;
  lsu_pkg::mem_req_t   req;
  logic                rsp_valid;
  logic                rsp_ready;
  lsu_pkg::mem_rsp_t   rsp;
  logic                fetch_req_valid;
  logic                fetch_req_ready;
  lsu_pkg::fetch_req_t fetch_req;
  logic                fetch_rsp_valid;
  logic                fetch_rsp_ready;
  lsu_pkg::word_t      fetch_inst;

  lsu_pkg::word_t    model [test_words];  // Mirror of the SRAM window.
  lsu_pkg::mem_rsp_t lsu_expect [$];      // In request order.
  lsu_pkg::word_t    inst_expect [$];
  logic [31:0]       lcg_state;
  time               lsu_valid_at;        // When the LSU response showed up.
  time               fetch_valid_at;      // When the fetch response showed up.

  mem_subsys #(
    .mem_words (1024)
  ) i_dut (
    .clk             (clk),
    .rst             (rst),
    .req_valid       (req_valid),
    .req_ready       (req_ready),
    .req             (req),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp             (rsp),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req_ready (fetch_req_ready),
    .fetch_req       (fetch_req),
    .fetch_rsp_valid (fetch_rsp_valid),
    .fetch_rsp_ready (fetch_rsp_ready),
    .fetch_inst      (fetch_inst)
  );

  always #50 clk = ~clk;  // 100 ns period.

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};  // Swap halves to hide the weak low bits.
  endfunction

  function automatic lsu_pkg::mem_size_t load_size(logic [31:0] k);
    case (k % 32'd5)
      32'd0:   return lsu_pkg::size_b;
      32'd1:   return lsu_pkg::size_h;
      32'd2:   return lsu_pkg::size_w;
      32'd3:   return lsu_pkg::size_bu;
      default: return lsu_pkg::size_hu;
    endcase
  endfunction

  function automatic lsu_pkg::mem_size_t store_size(logic [31:0] k);
    case (k % 32'd3)
      32'd0:   return lsu_pkg::size_b;
      32'd1:   return lsu_pkg::size_h;
      default: return lsu_pkg::size_w;
    endcase
  endfunction

  // Expected load value from the stored word.
  function automatic lsu_pkg::word_t ref_load(lsu_pkg::word_t w, logic [1:0] off,
                                              lsu_pkg::mem_size_t size);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[8*off +: 8];         // Byte lane.
    h = w[16*off[1] +: 16];    // Aligned half lane.
    case (size)
      lsu_pkg::size_b:  return {{24{b[7]}}, b};
      lsu_pkg::size_h:  return {{16{h[15]}}, h};
      lsu_pkg::size_bu: return {24'b0, b};
      lsu_pkg::size_hu: return {16'b0, h};
      default:          return w;
    endcase
  endfunction

  // Word after a store where only strobed lanes change.
  function automatic lsu_pkg::word_t ref_store(lsu_pkg::word_t w, logic [1:0] off,
                                               lsu_pkg::mem_size_t size, lsu_pkg::word_t d);
    lsu_pkg::word_t n;
    n = w;
    case (size)
      lsu_pkg::size_b, lsu_pkg::size_bu: n[8*off +: 8] = d[7:0];
      lsu_pkg::size_h, lsu_pkg::size_hu: n[16*off[1] +: 16] = d[15:0];
      default: n = d;
    endcase
    return n;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      abort_run("control signal has the wrong level");
    end
  endtask

  task automatic check_mem_rsp(input string name, input lsu_pkg::mem_rsp_t exp,
                               input lsu_pkg::mem_rsp_t act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      abort_run("LSU response data is wrong");
    end
  endtask

  task automatic check_inst(input string name, input lsu_pkg::word_t exp,
                            input lsu_pkg::word_t act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      abort_run("fetched instruction word is wrong");
    end
  endtask

  // Both units quiet and ready.
  task automatic verify_idle();
    check_bit("rsp_valid", 1'b0, rsp_valid);
    check_bit("fetch_rsp_valid", 1'b0, fetch_rsp_valid);
    check_bit("req_ready", 1'b1, req_ready);
    check_bit("fetch_req_ready", 1'b1, fetch_req_ready);
  endtask

  // Scoreboard sampled mid-cycle.
  always @(negedge clk) begin : compare
    lsu_pkg::mem_rsp_t exp_rsp;
    lsu_pkg::word_t    exp_inst;
    if (!rst && rsp_valid && rsp_ready) begin
      if (lsu_expect.size() == 0) abort_run("LSU response with no request outstanding");
      exp_rsp = lsu_expect.pop_front();
      check_mem_rsp("rsp", exp_rsp, rsp);
    end
    if (!rst && fetch_rsp_valid && fetch_rsp_ready) begin
      if (inst_expect.size() == 0) abort_run("fetch response with no request outstanding");
      exp_inst = inst_expect.pop_front();
      check_inst("fetch_inst", exp_inst, fetch_inst);
    end
  end

  task automatic lsu_request(input lsu_pkg::mem_req_t r);
    int n;
    n         = 0;
    req       = r;
    req_valid = 1'b1;
    @(negedge clk);
    while (!req_ready) begin
      n++;
      if (n > timeout_cycles) abort_run("LSU request channel never became ready");
      @(negedge clk);
    end
    @(posedge clk);  // Accepted here.
    #1;
    req_valid = 1'b0;
  endtask

  task automatic lsu_response(input int stall);
    int                n;
    lsu_pkg::mem_rsp_t held;
    n = 0;
    @(negedge clk);
    while (!rsp_valid) begin
      n++;
      if (n > timeout_cycles) abort_run("LSU response channel never became valid");
      @(negedge clk);
    end
    lsu_valid_at = $time;
    held         = rsp;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);  // Still back-pressured.
      check_bit("rsp_valid", 1'b1, rsp_valid);
      check_bit("req_ready", 1'b0, req_ready);
      check_mem_rsp("rsp", held, rsp);
    end
    @(posedge clk);
    #1;
    rsp_ready = 1'b1;
    @(posedge clk);  // Transfer.
    #1;
    rsp_ready = 1'b0;
    check_bit("req_ready", 1'b1, req_ready);
  endtask

  task automatic fetch_request(input lsu_pkg::fetch_req_t r);
    int n;
    n               = 0;
    fetch_req       = r;
    fetch_req_valid = 1'b1;
    @(negedge clk);
    while (!fetch_req_ready) begin
      n++;
      if (n > timeout_cycles) abort_run("fetch request channel never became ready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    fetch_req_valid = 1'b0;
  endtask

  task automatic fetch_response(input int stall);
    int             n;
    lsu_pkg::word_t held;
    n = 0;
    @(negedge clk);
    while (!fetch_rsp_valid) begin
      n++;
      if (n > timeout_cycles) abort_run("fetch response channel never became valid");
      @(negedge clk);
    end
    fetch_valid_at = $time;
    held           = fetch_inst;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      check_bit("fetch_rsp_valid", 1'b1, fetch_rsp_valid);
      check_bit("fetch_req_ready", 1'b0, fetch_req_ready);
      check_inst("fetch_inst", held, fetch_inst);
    end
    @(posedge clk);
    #1;
    fetch_rsp_ready = 1'b1;
    @(posedge clk);
    #1;
    fetch_rsp_ready = 1'b0;
    check_bit("fetch_req_ready", 1'b1, fetch_req_ready);
  endtask

  // One LSU access with its expected result taken from the model.
  task automatic lsu_op(input logic store, input lsu_pkg::mem_size_t size, input int widx,
                        input logic [1:0] off, input lsu_pkg::word_t data, input int stall);
    lsu_pkg::mem_req_t r;
    lsu_pkg::mem_rsp_t e;
    r.store = store;
    r.size  = size;
    r.addr  = {widx[29:0], off};
    r.data  = data;
    if (store) begin
      model[widx] = ref_store(model[widx], off, size, data);
      e.data      = '0;  // Stores answer with zero.
    end else begin
      e.data = ref_load(model[widx], off, size);
    end
    lsu_expect.push_back(e);
    lsu_request(r);
    lsu_response(stall);
  endtask

  task automatic fetch_op(input int widx, input logic [1:0] lo, input int stall);
    lsu_pkg::fetch_req_t r;
    r.pc = {widx[29:0], lo};  // Low bits ignored by the unit.
    inst_expect.push_back(model[widx]);
    fetch_request(r);
    fetch_response(stall);
  endtask

  initial begin : main
    logic [31:0]        rnd;
    int                 a;
    int                 f;
    int                 st;
    int                 st_f;
    logic               is_store;
    logic               lsu_first;
    lsu_pkg::mem_size_t sz;
    clk             = 1'b0;
    rst             = 1'b1;
    req_valid       = 1'b0;
    req             = '0;
    rsp_ready       = 1'b0;
    fetch_req_valid = 1'b0;
    fetch_req       = '0;
    fetch_rsp_ready = 1'b0;
    lcg_state       = 32'h92e1f684;
    lsu_valid_at    = 0;
    fetch_valid_at  = 0;
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      #1;
      verify_idle();
    end
    rst = 1'b0;
    @(posedge clk);  // First edge out of reset.
    #1;
    verify_idle();
    for (int w = 0; w < test_words; w++) begin
      lsu_op(1'b1, lsu_pkg::size_w, w, 2'b00, next_rand(), 0);  // Known contents.
    end
    for (int i = 0; i < 8; i++) begin
      a = int'(next_rand() % 32'd64);
      lsu_op(1'b1, lsu_pkg::size_w, a, 2'b00, next_rand(), int'(next_rand() % 32'd4));
      lsu_op(1'b0, lsu_pkg::size_w, a, 2'b00, '0, int'(next_rand() % 32'd4));
    end
    // Narrow stores at each lane followed by every load size.
    for (int i = 0; i < 64; i++) begin
      a  = int'(next_rand() % 32'd64);
      sz = i[2] ? lsu_pkg::size_h : lsu_pkg::size_b;
      lsu_op(1'b1, sz, a, i[1:0], next_rand(), int'(next_rand() % 32'd4));
      for (int k = 0; k < 5; k++) begin
        lsu_op(1'b0, load_size(k), a, i[1:0], '0, int'(next_rand() % 32'd4));
      end
    end
    for (int i = 0; i < 16; i++) begin
      rnd = next_rand();
      fetch_op(int'(rnd % 32'd64), rnd[9:8], int'(next_rand() % 32'd4));
    end
    // Both masters at once on different words.
    for (int i = 0; i < 48; i++) begin
      rnd      = next_rand();
      a        = int'(rnd % 32'd64);
      f        = (a + 1 + int'(next_rand() % 32'd63)) % test_words;
      is_store = rnd[12];
      sz       = is_store ? store_size(next_rand()) : load_size(next_rand());
      st       = int'(next_rand() % 32'd4);
      st_f     = int'(next_rand() % 32'd4);
      lsu_first = rnd[26];  // The master not served last wins the tie.
      if (lsu_first) begin
        fetch_op(f, 2'b00, 0);
      end else begin
        lsu_op(1'b0, lsu_pkg::size_w, a, 2'b00, '0, 0);
      end
      fork
        lsu_op(is_store, sz, a, rnd[17:16], next_rand(), st);
        fetch_op(f, rnd[21:20], st_f);
      join
      if ((lsu_valid_at < fetch_valid_at) != lsu_first) begin
        abort_run("tied requests were not granted to the master served less recently");
      end
    end
    if (lsu_expect.size() != 0 || inst_expect.size() != 0) begin
      abort_run("responses still outstanding at the end of the run");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire
